/* design/basicOps.sv */
`timescale 1ns/10ps

module basicOps
	import percVarPkg::*;
(
	input  logic clk,
	input  logic arstN,
	opBus.ops    bus
);

	logic signed [15:0]       a16;
	logic signed [15:0]       b16;
	logic signed [16:0]       sum17;
	logic signed [16:0]       diff17;
	logic signed [31:0]       prod;
	logic        [4:0]        shr16Amt;
	logic        [4:0]        shr32Amt;
	logic        [DATA_W-1:0] nextResult;

	// Clamp a 17-bit intermediate into the 16-bit range
	function automatic logic [15:0] sat16(input logic signed [16:0] v);
		if (v[16] != v[15])
			return v[16] ? 16'h8000 : 16'h7fff;
		return v[15:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Operand views
	////////////////////////////////////////////////////////////////////////////

	assign a16    = bus.a[15:0];
	assign b16    = bus.b[15:0];
	assign sum17  = a16 + b16;
	assign diff17 = a16 - b16;
	assign prod   = a16 * b16;

	// Shift counts stop at the operand width, as in the ITU reference
	assign shr16Amt = (bus.b[15:0] > 16'd15) ? 5'd15 : bus.b[4:0];
	assign shr32Amt = (bus.b[15:0] > 16'd31) ? 5'd31 : bus.b[4:0];

	////////////////////////////////////////////////////////////////////////////
	// Operator select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (bus.op)
			OP_ADD:
				nextResult = sext16(sat16(sum17));
			OP_SUB:
				nextResult = sext16(sat16(diff17));
			OP_SHR:
				nextResult = sext16(a16 >>> shr16Amt);
			OP_LMULT:
			begin
				// Only -32768 * -32768 overflows when doubled
				if (prod == 32'sh4000_0000)
					nextResult = 32'h7fff_ffff;
				else
					nextResult = {prod[30:0], 1'b0};
			end
			OP_LSHR:
				nextResult = $signed(bus.a) >>> shr32Amt;
			default:
				nextResult = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			bus.result <= '0;
		else
			bus.result <= nextResult;
	end

	// Controller never issues an undefined opcode
	opValid: assert property (@(posedge clk) disable iff (!arstN)
		bus.op inside {OP_ADD, OP_SUB, OP_SHR, OP_LMULT, OP_LSHR});

endmodule

/* design/memBus.sv */
`timescale 1ns/10ps

interface memBus import percVarPkg::*; ();

	// Controller side of the scratch RAM
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              we;

	// Registered read data, one cycle after addr
	logic [DATA_W-1:0] rdata;

	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

/* design/opBus.sv */
`timescale 1ns/10ps

interface opBus import percVarPkg::*; ();

	// Operator request
	opCode_e           op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;

	// Result, one cycle after the request
	logic [DATA_W-1:0] result;

	modport ctrl (
		output op,
		output a,
		output b,
		input  result
	);

	modport ops (
		input  op,
		input  a,
		input  b,
		output result
	);

endinterface

/* design/percVarCtrl.sv */
`timescale 1ns/10ps

module percVarCtrl
	import percVarPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic start,
	output logic done,
	output logic busy,
	memBus.ctrl  mem,
	opBus.ctrl   ops
);

	ctrlState_e         state;
	ctrlState_e         nextState;
	logic [IDX_W-1:0]   idx;
	logic [15:0]        aReg;
	logic [15:0]        interReg;
	logic signed [15:0] gammaRaw;
	logic signed [15:0] gammaClip;
	logic               lastItem;

	assign lastItem = (idx == IDX_W'(ITEM_COUNT - 1));

	////////////////////////////////////////////////////////////////////////////
	// State sequencing at eight cycles per item
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			S_IDLE:  nextState = start ? S_RDA : S_IDLE;
			S_RDA:   nextState = S_RDB;
			S_RDB:   nextState = S_ADD;
			S_ADD:   nextState = S_SHR;
			S_SHR:   nextState = S_LMULT;
			S_LMULT: nextState = S_LSHR;
			S_LSHR:  nextState = S_SUB;
			S_SUB:   nextState = S_WRITE;
			S_WRITE: nextState = lastItem ? S_DONE : S_RDA;
			default: nextState = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= S_IDLE;
			idx   <= '0;
			busy  <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (state == S_IDLE && start)
			begin
				busy <= 1'b1;
				idx  <= '0;
			end
			if (state == S_WRITE)
			begin
				idx <= idx + 1'b1;
				// Hand the RAM back as the last word lands
				if (lastItem)
					busy <= 1'b0;
			end
		end
	end

	// Operand a arrives in S_RDB and inter leaves the shifter in S_LMULT
	always_ff @(posedge clk)
	begin
		if (state == S_RDB)
			aReg <= mem.rdata[15:0];
		if (state == S_LMULT)
			interReg <= ops.result[15:0];
	end

	assign done = (state == S_DONE);

	////////////////////////////////////////////////////////////////////////////
	// Memory and operator requests
	////////////////////////////////////////////////////////////////////////////

	assign gammaRaw  = ops.result[15:0];
	assign gammaClip = (gammaRaw > GAMMA_MAX) ? GAMMA_MAX :
		(gammaRaw < GAMMA_MIN) ? GAMMA_MIN : gammaRaw;

	always_comb
	begin
		mem.addr  = OUT_BASE + ADDR_W'(idx);
		mem.wdata = {interReg, gammaClip};
		mem.we    = 1'b0;
		case (state)
			S_RDA:   mem.addr = A_BASE + ADDR_W'(idx);
			S_RDB:   mem.addr = B_BASE + ADDR_W'(idx);
			S_WRITE: mem.we = 1'b1;
			default: mem.we = 1'b0;
		endcase
	end

	always_comb
	begin
		ops.op = OP_ADD;
		ops.a  = '0;
		ops.b  = '0;
		case (state)
			S_ADD:
			begin
				// b comes straight from the RAM read port
				ops.a = sext16(aReg);
				ops.b = sext16(mem.rdata[15:0]);
			end
			S_SHR:
			begin
				ops.op = OP_SHR;
				ops.a  = ops.result;
				ops.b  = 32'd1;
			end
			S_LMULT:
			begin
				ops.op = OP_LMULT;
				ops.a  = ops.result;
				ops.b  = sext16(GAMMA_SLOPE);
			end
			S_LSHR:
			begin
				ops.op = OP_LSHR;
				ops.a  = ops.result;
				ops.b  = 32'd16;
			end
			S_SUB:
			begin
				ops.op = OP_SUB;
				ops.a  = sext16(GAMMA_OFFSET);
				ops.b  = ops.result;
			end
			default:
				ops.op = OP_ADD;
		endcase
	end

	busyNotIdle: assert property (@(posedge clk) disable iff (!arstN)
		busy |-> state != S_IDLE);

endmodule

/* design/percVarPkg.sv */
package percVarPkg;

	////////////////////////////////////////////////////////////////////////////
	// Scratch memory geometry and layout
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_W    = 11;
	localparam int DATA_W    = 32;
	localparam int MEM_DEPTH = 2048;

	// Operand and result regions
	localparam logic [ADDR_W-1:0] A_BASE   = 11'd0;
	localparam logic [ADDR_W-1:0] B_BASE   = 11'd16;
	localparam logic [ADDR_W-1:0] OUT_BASE = 11'd32;

	localparam int ITEM_COUNT = 8;
	localparam int IDX_W      = $clog2(ITEM_COUNT);

	////////////////////////////////////////////////////////////////////////////
	// Gamma constants, Q15
	////////////////////////////////////////////////////////////////////////////

	localparam logic signed [15:0] GAMMA_SLOPE  = 16'sd16384;
	localparam logic signed [15:0] GAMMA_OFFSET = 16'sd24576;
	localparam logic signed [15:0] GAMMA_MIN    = 16'sd19661;
	localparam logic signed [15:0] GAMMA_MAX    = 16'sd29491;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_SHR,
		OP_LMULT,
		OP_LSHR
	} opCode_e;

	typedef enum logic [3:0] {
		S_IDLE,
		S_RDA,
		S_RDB,
		S_ADD,
		S_SHR,
		S_LMULT,
		S_LSHR,
		S_SUB,
		S_WRITE,
		S_DONE
	} ctrlState_e;

	// Sign extension of a 16-bit word to the bus width
	function automatic logic [DATA_W-1:0] sext16(input logic [15:0] v);
		return {{(DATA_W-16){v[15]}}, v};
	endfunction

endpackage

/* design/percVarTop.sv */
`timescale 1ns/10ps

module percVarTop
	import percVarPkg::*;
(
	input  logic              clk,
	input  logic              arstN,
	input  logic              start,
	output logic              done,
	output logic              busy,
	input  logic              wbCyc,
	input  logic              wbStb,
	input  logic              wbWe,
	input  logic [ADDR_W-1:0] wbAdr,
	input  logic [DATA_W-1:0] wbDatW,
	output logic [DATA_W-1:0] wbDatR,
	output logic              wbAck
);

	memBus memIf();
	opBus  opIf();

	// Sequencer
	percVarCtrl u_ctrl (
		.clk   (clk),
		.arstN (arstN),
		.start (start),
		.done  (done),
		.busy  (busy),
		.mem   (memIf.ctrl),
		.ops   (opIf.ctrl)
	);

	basicOps u_ops (
		.clk   (clk),
		.arstN (arstN),
		.bus   (opIf.ops)
	);

	// Shared scratch RAM with the host port
	scratchMem u_mem (
		.clk    (clk),
		.arstN  (arstN),
		.busy   (busy),
		.port   (memIf.mem),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbDatR (wbDatR),
		.wbAck  (wbAck)
	);

endmodule

/* design/scratchMem.sv */
`timescale 1ns/10ps

module scratchMem
	import percVarPkg::*;
(
	input  logic              clk,
	input  logic              arstN,
	input  logic              busy,
	memBus.mem                port,
	input  logic              wbCyc,
	input  logic              wbStb,
	input  logic              wbWe,
	input  logic [ADDR_W-1:0] wbAdr,
	input  logic [DATA_W-1:0] wbDatW,
	output logic [DATA_W-1:0] wbDatR,
	output logic              wbAck
);

	logic [DATA_W-1:0] ram [MEM_DEPTH];
	logic [ADDR_W-1:0] ramAddr;
	logic [DATA_W-1:0] ramWdata;
	logic              ramWe;
	logic [DATA_W-1:0] rdataQ;
	logic              wbGrant;

	// Host gets one access per request and only while the FSM is idle
	assign wbGrant = wbCyc && wbStb && !busy && !wbAck;

	// Owner select
	always_comb
	begin
		if (busy)
		begin
			ramAddr  = port.addr;
			ramWdata = port.wdata;
			ramWe    = port.we;
		end
		else
		begin
			ramAddr  = wbAdr;
			ramWdata = wbDatW;
			ramWe    = wbGrant && wbWe;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ramWe)
			ram[ramAddr] <= ramWdata;
		rdataQ <= ram[ramAddr];
	end

	assign port.rdata = rdataQ;
	assign wbDatR     = rdataQ;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			wbAck <= 1'b0;
		else
			wbAck <= wbGrant;
	end

	ackAfterStb: assert property (@(posedge clk) disable iff (!arstN)
		wbAck |-> $past(wbCyc && wbStb));

	// Host is never acknowledged while the FSM owns the RAM
	noAckWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
		busy |-> !wbAck);

endmodule

/* percVar.f */
design/percVarPkg.sv
design/memBus.sv
design/opBus.sv
design/basicOps.sv
design/scratchMem.sv
design/percVarCtrl.sv
design/percVarTop.sv
testbench/percVarTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module percVarTb -f percVar.f -o simPercVar
./obj_dir/simPercVar > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without errors"

/* testbench/percVarTb.sv */
`timescale 1ns/10ps

module percVarTb
	import percVarPkg::*;
();

	localparam int          CLK_PERIOD  = 40;
	localparam int          NUM_TESTS   = 6;
	localparam int          TEST_CYCLES = ITEM_COUNT * 10 + 200;
	localparam int          WB_CHECKS   = 16;
	localparam logic [31:0] SEED        = 32'h05a5a9b2;

	logic              clk;
	logic              arstN;
	logic              start;
	logic              done;
	logic              busy;
	logic              wbCyc;
	logic              wbStb;
	logic              wbWe;
	logic [ADDR_W-1:0] wbAdr;
	logic [DATA_W-1:0] wbDatW;
	logic [DATA_W-1:0] wbDatR;
	logic              wbAck;

	logic [15:0] aVals [ITEM_COUNT];
	logic [15:0] bVals [ITEM_COUNT];
	int          errorCount;

	percVarTop u_dut (
		.clk    (clk),
		.arstN  (arstN),
		.start  (start),
		.done   (done),
		.busy   (busy),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbDatR (wbDatR),
		.wbAck  (wbAck)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Budget covers every test at its worst length
	initial
	begin
		#(TEST_CYCLES * NUM_TESTS * CLK_PERIOD);
		$display("Watchdog expired, the simulation ran longer than expected");
		$display("TEST FAILED");
		$fatal(1, "Watchdog timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// Expected result of one item
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] refPercVar(input logic [15:0] a, input logic [15:0] b);
		int                 sum;
		int                 inter;
		int                 prod16;
		int                 gamma;
		longint             lprod;
		logic [31:0]        l32;
		logic signed [15:0] p16;
		sum = int'($signed(a)) + int'($signed(b));
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		inter = sum >>> 1;
		// L_mult doubles the product
		lprod = longint'(inter) * longint'(GAMMA_SLOPE) * 2;
		if (lprod > 64'sd2147483647)
			lprod = 64'sd2147483647;
		else if (lprod < -64'sd2147483648)
			lprod = -64'sd2147483648;
		l32 = lprod[31:0];
		p16 = l32[31:16];
		prod16 = p16;
		gamma = int'(GAMMA_OFFSET) - prod16;
		if (gamma > 32767)
			gamma = 32767;
		else if (gamma < -32768)
			gamma = -32768;
		if (gamma > GAMMA_MAX)
			gamma = GAMMA_MAX;
		else if (gamma < GAMMA_MIN)
			gamma = GAMMA_MIN;
		return {inter[15:0], gamma[15:0]};
	endfunction

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Next drive and sample point, just after the rising edge
	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////////////////////

	task automatic wbWrite(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = 1'b1;
		wbAdr  = addr;
		wbDatW = data;
		do
			stepCycle();
		while (!wbAck);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	// Counts the cycles the request spent stalled behind busy
	task automatic wbRead(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
		output int stalls);
		logic prevBusy;
		stalls   = 0;
		wbCyc    = 1'b1;
		wbStb    = 1'b1;
		wbWe     = 1'b0;
		wbAdr    = addr;
		prevBusy = busy;
		stepCycle();
		while (!wbAck)
		begin
			if (busy)
				stalls++;
			prevBusy = busy;
			stepCycle();
		end
		checkEq(32'(prevBusy), 32'd0, "wbAck granted while busy");
		data  = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Controller runs
	////////////////////////////////////////////////////////////////////////////

	task automatic pulseStart();
		start = 1'b1;
		stepCycle();
		start = 1'b0;
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (!done)
		begin
			if (cycles > TEST_CYCLES)
			begin
				$display("Controller never raised done after start");
				$display("TEST FAILED");
				$fatal(1, "Done timeout");
			end
			else
			begin
				stepCycle();
				cycles++;
			end
		end
		checkEq(32'(busy), 32'd0, "busy still high with done");
	endtask

	task automatic countDone(input int cycles, output int pulses);
		pulses = 0;
		repeat (cycles)
		begin
			stepCycle();
			if (done)
				pulses++;
		end
	endtask

	task automatic randomItems();
		for (int i = 0; i < ITEM_COUNT; i++)
		begin
			aVals[i] = 16'($urandom);
			bVals[i] = 16'($urandom);
		end
	endtask

	// Upper halves carry noise, only the low halves are operands
	task automatic loadItems();
		for (int i = 0; i < ITEM_COUNT; i++)
		begin
			wbWrite(A_BASE + ADDR_W'(i), {16'($urandom), aVals[i]});
			wbWrite(B_BASE + ADDR_W'(i), {16'($urandom), bVals[i]});
		end
	endtask

	task automatic checkItems();
		logic [31:0] data;
		int          stalls;
		for (int i = 0; i < ITEM_COUNT; i++)
		begin
			wbRead(OUT_BASE + ADDR_W'(i), data, stalls);
			checkEq(data, refPercVar(aVals[i], bVals[i]), $sformatf("result of item %0d", i));
		end
	endtask

	task automatic runItems();
		pulseStart();
		checkEq(32'(busy), 32'd1, "busy after start");
		waitDone();
		checkItems();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testWbAccess();
		logic [ADDR_W-1:0] addrs [WB_CHECKS];
		logic [31:0]       vals  [WB_CHECKS];
		logic [31:0]       data;
		int                stalls;
		// One address per 128-word slice keeps them distinct
		for (int i = 0; i < WB_CHECKS; i++)
		begin
			addrs[i] = ADDR_W'(i * 128) + ADDR_W'($urandom % 128);
			vals[i]  = $urandom;
			wbWrite(addrs[i], vals[i]);
		end
		for (int i = 0; i < WB_CHECKS; i++)
		begin
			wbRead(addrs[i], data, stalls);
			checkEq(data, vals[i], $sformatf("readback at %h", addrs[i]));
		end
	endtask

	task automatic testCorners();
		logic [31:0] data;
		int          stalls;
		randomItems();
		aVals[0] = 16'h7fff;
		bVals[0] = 16'h7fff;
		aVals[1] = 16'h8000;
		bVals[1] = 16'h8000;
		// inter of -16384
		aVals[2] = 16'hc000;
		bVals[2] = 16'hc000;
		aVals[3] = 16'h4000;
		bVals[3] = 16'h3000;
		aVals[4] = 16'hffff;
		bVals[4] = 16'h0000;
		loadItems();
		runItems();
		wbRead(OUT_BASE + ADDR_W'(2), data, stalls);
		checkEq(32'(data[15:0]), 32'(GAMMA_MAX), "gamma clip to maximum");
		wbRead(OUT_BASE + ADDR_W'(3), data, stalls);
		checkEq(32'(data[15:0]), 32'(GAMMA_MIN), "gamma clip to minimum");
	endtask

	task automatic testReadWhileBusy();
		logic [31:0] data;
		int          stalls;
		randomItems();
		loadItems();
		fork
			begin
				pulseStart();
				waitDone();
			end
			begin
				repeat (4) stepCycle();
				wbRead(OUT_BASE + ADDR_W'(ITEM_COUNT - 1), data, stalls);
			end
		join
		checkEq(32'(stalls > 0), 32'd1, "read was not stalled by busy");
		checkEq(data, refPercVar(aVals[ITEM_COUNT-1], bVals[ITEM_COUNT-1]),
			"stalled read data");
		checkItems();
	endtask

	task automatic testDoubleStart();
		int extra;
		randomItems();
		loadItems();
		pulseStart();
		repeat (3) stepCycle();
		pulseStart();
		waitDone();
		countDone(ITEM_COUNT * 8 + 10, extra);
		checkEq(32'(extra), 32'd0, "extra done pulses after second start");
		checkItems();
	endtask

	initial
	begin
		errorCount = 0;
		void'($urandom(SEED));
		arstN  = 1'b0;
		start  = 1'b0;
		wbCyc  = 1'b0;
		wbStb  = 1'b0;
		wbWe   = 1'b0;
		wbAdr  = '0;
		wbDatW = '0;
		repeat (16) @(posedge clk);
		#2;
		arstN = 1'b1;

		checkEq(32'(done), 32'd0, "done after reset");
		checkEq(32'(busy), 32'd0, "busy after reset");
		checkEq(32'(wbAck), 32'd0, "wbAck after reset");

		testWbAccess();
		repeat (2)
		begin
			randomItems();
			loadItems();
			runItems();
		end
		testCorners();
		testReadWhileBusy();
		testDoubleStart();

		if (errorCount == 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1, "Errors were found");
		end
	end

endmodule
